// ==== orde_resp_buf.f ====
+incdir+source
source/orde_pkg.sv
source/orde_base_regs.sv
source/orde_indirect_rewrite.sv
source/orde_resp_store.sv
source/orde_dup_filter.sv
source/orde_resp_buf.sv
verif/orde_resp_buf_props.sv
verif/orde_resp_buf_tb.sv

// ==== Bender.yml ====
package:
  name: orde_resp_buf

sources:
  - include_dirs:
      - source
    files:
      - source/orde_pkg.sv
      - source/orde_base_regs.sv
      - source/orde_indirect_rewrite.sv
      - source/orde_resp_store.sv
      - source/orde_dup_filter.sv
      - source/orde_resp_buf.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/orde_resp_buf_props.sv
      - verif/orde_resp_buf_tb.sv

// ==== verif/orde_resp_buf_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "orde_defines.svh"

module orde_resp_buf_tb
  import orde_pkg::*;
();

  localparam int CLK_NS    = 10;
  localparam int DEPTH     = `ORDE_DEPTH;
  localparam int DRAIN_MAX = 64;
  localparam int RDY_MAX   = 100;
  // cycle budget per test, the watchdog fires after their sum
  localparam int RUN_CYC   = 10 + 40 + 100 + 90 + 100 + 80 + 200;

  logic clk;
  logic rst;
  logic i_pkt_valid;
  orde_meta_t i_pkt_meta;
  logic [`ORDE_DATA_W-1:0] i_pkt_data;
  logic o_pkt_rdy;
  logic i_psel;
  logic i_penable;
  logic i_pwrite;
  logic [`ORDE_APB_AW-1:0] i_paddr;
  logic [31:0] i_pwdata;
  logic [31:0] o_prdata;
  logic o_pready;
  logic o_pslverr;
  orde_meta_t o_meta;
  logic o_meta_valid;
  logic i_data_pop;
  logic [`ORDE_DATA_W-1:0] o_data;

  // reference model state
  logic [`ORDE_DATA_W-1:0] exp_data[$];
  int data_vis[$];
  orde_meta_t exp_meta[$];
  orde_meta_t hist1;
  orde_meta_t hist2;
  orde_meta_t meta_exp;
  logic [`ORDE_DATA_W-1:0] data_exp;
  logic [31:0] base_a_m;
  logic [31:0] base_b_m;
  logic [31:0] base_c_m;
  logic [31:0] apb_rd_exp;
  logic apb_err_exp;
  logic acc_pending;
  logic meta_avail;
  int hist_n;
  int occ;
  int pop_budget;
  int edge_no = 0;
  int seed = 28;
  int err_cnt = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int test_err0 = 0;
  int seq5[11] = '{1, 2, 3, 4, 5, 4, 5, 3, 5, 3, 2};

  orde_resp_buf orde_resp_buf_inst (
    .clk (clk), .rst (rst),
    .i_pkt_valid (i_pkt_valid), .i_pkt_meta (i_pkt_meta),
    .i_pkt_data (i_pkt_data), .o_pkt_rdy (o_pkt_rdy),
    .i_psel (i_psel), .i_penable (i_penable), .i_pwrite (i_pwrite),
    .i_paddr (i_paddr), .i_pwdata (i_pwdata), .o_prdata (o_prdata),
    .o_pready (o_pready), .o_pslverr (o_pslverr),
    .o_meta (o_meta), .o_meta_valid (o_meta_valid),
    .i_data_pop (i_data_pop), .o_data (o_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  always @(posedge clk) edge_no <= edge_no + 1;

  // occupancy as the DUT should count it
  always @(posedge clk or posedge rst) begin
    if (rst) begin
      occ <= 0;
    end else begin
      occ <= occ + (acc_pending ? 1 : 0) - (i_data_pop ? 1 : 0);
    end
  end

  // consumer pops only words that have had an edge to reach o_data
  always @(negedge clk) begin
    if (!rst && pop_budget > 0 && exp_data.size() > 0 && data_vis[0] <= edge_no) begin
      data_exp = exp_data.pop_front();
      data_vis.delete(0);
      pop_budget--;
      i_data_pop = 1'b1;
    end else begin
      i_data_pop = 1'b0;
    end
  end

  // a valid pulse is checked at the next edge against the queue head
  always @(negedge clk) begin
    if (o_meta_valid) begin
      meta_avail = (exp_meta.size() > 0);
      if (meta_avail) begin
        meta_exp = exp_meta.pop_front();
      end
    end
  end

  data_chk: assert property (@(posedge clk) disable iff (rst) i_data_pop |-> o_data == data_exp)
    else begin
      err_cnt++;
      $display("ERROR %0t o_data expected %h got %h", $time, data_exp, $sampled(o_data));
    end

  meta_extra: assert property (@(posedge clk) disable iff (rst) o_meta_valid |-> meta_avail)
    else begin
      err_cnt++;
      $display("metadata presented at %0t when none was expected", $time);
    end

  meta_chk: assert property (@(posedge clk) disable iff (rst)
    (o_meta_valid && meta_avail) |-> o_meta == meta_exp)
    else begin
      err_cnt++;
      $display("ERROR %0t o_meta expected %h got %h", $time, meta_exp, $sampled(o_meta));
    end

  rdy_chk: assert property (@(posedge clk) disable iff (rst) o_pkt_rdy == (occ < DEPTH - 2))
    else begin
      err_cnt++;
      $display("ERROR %0t o_pkt_rdy expected %b got %b", $time, occ < DEPTH - 2,
               $sampled(o_pkt_rdy));
    end

  prdata_chk: assert property (@(posedge clk) disable iff (rst)
    (i_psel && i_penable && !i_pwrite) |-> o_prdata == apb_rd_exp)
    else begin
      err_cnt++;
      $display("ERROR %0t o_prdata expected %h got %h", $time, apb_rd_exp, $sampled(o_prdata));
    end

  pslverr_chk: assert property (@(posedge clk) disable iff (rst)
    (i_psel && i_penable) |-> o_pslverr == apb_err_exp)
    else begin
      err_cnt++;
      $display("ERROR %0t o_pslverr expected %b got %b", $time, apb_err_exp,
               $sampled(o_pslverr));
    end

  function automatic int total_errors();
    return err_cnt + orde_resp_buf_inst.props_inst.fail_cnt;
  endfunction

  function automatic logic [255:0] rand_word();
    logic [255:0] w;
    for (int i = 0; i < 8; i++) begin
      w[i*32 +: 32] = $random(seed);
    end
    return w;
  endfunction

  function automatic orde_meta_t rand_meta();
    logic [31:0] r;
    r = $random(seed);
    return orde_meta_t'(r[30:0]);
  endfunction

  // descriptor: addr_l in bits 31:0, addr_h 63:32, off_ab 95:64, off_c 159:128, opcode on top
  function automatic logic [255:0] expect_word(input logic [255:0] w);
    logic [31:0] lo;
    logic [31:0] op;
    logic [255:0] r;
    lo = w[31:0];
    op = w[255:224];
    r = w;
    if (w[63:32] == 32'd4 && lo[31:24] == 8'h00 && lo[23] &&
        (lo[5:0] == 6'd3 || lo[5:0] == 6'd5) && lo[0] && lo[1]) begin
      if (op[1]) begin
        r[95:64] = w[95:64] + base_a_m;
      end else if (op[2]) begin
        r[95:64] = w[95:64] + base_b_m;
      end else if (op[3]) begin
        r[159:128] = w[159:128] + base_c_m;
      end
    end
    return r;
  endfunction

  function automatic logic [255:0] make_desc(input logic [5:0] mode, input logic [31:0] hi,
                                             input logic [31:0] op);
    logic [255:0] w;
    w = rand_word();
    w[31:23] = 9'h001;
    w[5:0] = mode;
    w[63:32] = hi;
    w[255:224] = op;
    return w;
  endfunction

  // entry equal to either of the last two shown is never shown
  task automatic note_meta(input orde_meta_t m);
    if (!((hist_n >= 1 && m == hist1) || (hist_n >= 2 && m == hist2))) begin
      exp_meta.push_back(m);
      hist2 = hist1;
      hist1 = m;
      hist_n++;
    end
  endtask

  task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] data);
    logic mapped;
    mapped = (addr == `ORDE_REG_A_OFS) || (addr == `ORDE_REG_B_OFS) ||
             (addr == `ORDE_REG_C_OFS);
    @(negedge clk);
    i_psel = 1'b1;
    i_pwrite = wr;
    i_paddr = addr;
    i_pwdata = data;
    apb_err_exp = !mapped;
    apb_rd_exp = (addr == `ORDE_REG_A_OFS) ? base_a_m :
                 (addr == `ORDE_REG_B_OFS) ? base_b_m :
                 (addr == `ORDE_REG_C_OFS) ? base_c_m : 32'h0;
    @(negedge clk);
    i_penable = 1'b1;
    @(negedge clk);
    i_psel = 1'b0;
    i_penable = 1'b0;
    if (wr && addr == `ORDE_REG_A_OFS) base_a_m = data;
    if (wr && addr == `ORDE_REG_B_OFS) base_b_m = data;
    if (wr && addr == `ORDE_REG_C_OFS) base_c_m = data;
  endtask

  task automatic send_pkt(input orde_meta_t meta, input logic [255:0] word);
    int waited;
    waited = 0;
    @(negedge clk);
    i_pkt_valid = 1'b1;
    i_pkt_meta = meta;
    i_pkt_data = word;
    while (!o_pkt_rdy && waited < RDY_MAX) begin
      acc_pending = 1'b0;
      @(negedge clk);
      waited++;
    end
    accept_seen: assert (o_pkt_rdy) else begin
      err_cnt++;
      $display("packet offered at %0t was never accepted", $time);
    end
    if (o_pkt_rdy) begin
      acc_pending = 1'b1;
      exp_data.push_back(expect_word(word));
      data_vis.push_back(edge_no + 2);
      note_meta(meta);
    end else begin
      acc_pending = 1'b0;
      i_pkt_valid = 1'b0;
    end
  endtask

  task automatic pkt_idle();
    @(negedge clk);
    i_pkt_valid = 1'b0;
    acc_pending = 1'b0;
  endtask

  task automatic set_budget(input int n);
    @(posedge clk);
    pop_budget = n;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_data.size() > 0 || exp_meta.size() > 0) && n < DRAIN_MAX) begin
      @(posedge clk);
      n++;
    end
    repeat (4) @(posedge clk);
    drained: assert (exp_data.size() == 0 && exp_meta.size() == 0) else begin
      err_cnt++;
      $display("buffer did not drain at %0t, %0d words and %0d metadata entries missing",
               $time, exp_data.size(), exp_meta.size());
    end
    exp_data.delete();
    data_vis.delete();
    exp_meta.delete();
  endtask

  task automatic finish_test(input string name);
    int now_err;
    now_err = total_errors();
    tests_run++;
    if (now_err == test_err0) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, now_err - test_err0);
    end
    test_err0 = now_err;
  endtask

  initial begin
    rst = 1'b1;
    i_pkt_valid = 1'b0;
    i_pkt_meta = '0;
    i_pkt_data = '0;
    i_psel = 1'b0;
    i_penable = 1'b0;
    i_pwrite = 1'b0;
    i_paddr = '0;
    i_pwdata = '0;
    i_data_pop = 1'b0;
    acc_pending = 1'b0;
    apb_err_exp = 1'b0;
    apb_rd_exp = '0;
    meta_avail = 1'b0;
    pop_budget = 0;
    hist_n = 0;
    base_a_m = '0;
    base_b_m = '0;
    base_c_m = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    apb_xfer(1'b0, `ORDE_REG_A_OFS, 32'h0);
    apb_xfer(1'b1, `ORDE_REG_A_OFS, 32'h1234_5678);
    apb_xfer(1'b1, `ORDE_REG_B_OFS, 32'h8000_0001);
    apb_xfer(1'b1, `ORDE_REG_C_OFS, 32'hdead_beef);
    apb_xfer(1'b1, 4'hc, 32'hffff_ffff);
    apb_xfer(1'b0, `ORDE_REG_A_OFS, 32'h0);
    apb_xfer(1'b0, `ORDE_REG_B_OFS, 32'h0);
    apb_xfer(1'b0, `ORDE_REG_C_OFS, 32'h0);
    apb_xfer(1'b0, 4'hc, 32'h0);
    apb_xfer(1'b0, 4'h2, 32'h0);
    finish_test("apb_regs");

    set_budget(1000);
    repeat (24) send_pkt(rand_meta(), rand_word());
    pkt_idle();
    wait_drain();
    finish_test("plain_data");

    // base a near the top so the sum wraps
    apb_xfer(1'b1, `ORDE_REG_A_OFS, 32'hffff_fff0);
    apb_xfer(1'b1, `ORDE_REG_B_OFS, 32'h0000_1000);
    apb_xfer(1'b1, `ORDE_REG_C_OFS, 32'h0100_0000);
    send_pkt(rand_meta(), make_desc(6'd3, 32'd4, 32'h2));
    send_pkt(rand_meta(), make_desc(6'd3, 32'd4, 32'h6));
    send_pkt(rand_meta(), make_desc(6'd3, 32'd4, 32'h4));
    send_pkt(rand_meta(), make_desc(6'd3, 32'd4, 32'hc));
    send_pkt(rand_meta(), make_desc(6'd3, 32'd4, 32'h8));
    send_pkt(rand_meta(), make_desc(6'd3, 32'd4, 32'h1));
    send_pkt(rand_meta(), make_desc(6'd5, 32'd4, 32'h2));
    send_pkt(rand_meta(), make_desc(6'd3, 32'd5, 32'h2));
    pkt_idle();
    wait_drain();
    finish_test("rewrite");

    set_budget(0);
    repeat (DEPTH - 2) send_pkt(rand_meta(), rand_word());
    fork
      send_pkt(rand_meta(), rand_word());
      begin
        repeat (6) @(posedge clk);
        pop_budget = 1;
      end
    join
    pkt_idle();
    set_budget(1000);
    wait_drain();
    finish_test("backpressure");

    foreach (seq5[i]) begin
      send_pkt(orde_meta_t'({1'b1, 30'(seq5[i] * 1000 + 17)}), rand_word());
    end
    pkt_idle();
    wait_drain();
    finish_test("dup_filter");

    $display("tests %0d, passed %0d, failed %0d, errors %0d", tests_run,
             tests_run - tests_failed, tests_failed, total_errors());
    if (total_errors() == 0 && tests_failed == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(RUN_CYC * CLK_NS);
    $display("watchdog expired after %0d cycles, the run did not complete", RUN_CYC);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/orde_resp_buf_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module orde_resp_buf_props (
  input logic       clk,
  input logic       rst,
  input logic       i_pkt_valid,
  input logic       i_pkt_rdy,
  input logic       i_meta_valid,
  input logic       i_pready,
  input logic [3:0] i_data_cnt
);

  int unsigned fail_cnt = 0;

  // buffer ready and metadata quiet while in reset
  rst_idle: assert property (@(posedge clk) rst |-> i_pkt_rdy && !i_meta_valid)
    else begin
      fail_cnt++;
      $error("ready low or metadata valid during reset");
    end

  // and on the first edge after it
  rst_exit: assert property (@(posedge clk) $fell(rst) |-> i_pkt_rdy && !i_meta_valid)
    else begin
      fail_cnt++;
      $error("ready low or metadata valid right after reset");
    end

  pready_high: assert property (@(posedge clk) i_pready)
    else begin
      fail_cnt++;
      $error("apb pready dropped");
    end

  // occupancy may not grow from a packet offered while not ready
  no_accept: assert property (@(posedge clk) disable iff (rst)
    (i_pkt_valid && !i_pkt_rdy) |=> i_data_cnt <= $past(i_data_cnt))
    else begin
      fail_cnt++;
      $error("packet taken while o_pkt_rdy was low");
    end

endmodule

bind orde_resp_buf orde_resp_buf_props props_inst (
  .clk          (clk),
  .rst          (rst),
  .i_pkt_valid  (i_pkt_valid),
  .i_pkt_rdy    (o_pkt_rdy),
  .i_meta_valid (o_meta_valid),
  .i_pready     (o_pready),
  .i_data_cnt   (u_resp_store.data_cnt)
);

`default_nettype wire

// ==== source/orde_resp_buf.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "orde_defines.svh"

module orde_resp_buf
  import orde_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  // response packets
  input  logic                    i_pkt_valid,
  input  orde_meta_t              i_pkt_meta,
  input  logic [`ORDE_DATA_W-1:0] i_pkt_data,
  output logic                    o_pkt_rdy,
  // apb slave
  input  logic                    i_psel,
  input  logic                    i_penable,
  input  logic                    i_pwrite,
  input  logic [`ORDE_APB_AW-1:0] i_paddr,
  input  logic [31:0]             i_pwdata,
  output logic [31:0]             o_prdata,
  output logic                    o_pready,
  output logic                    o_pslverr,
  // ordered outputs
  output orde_meta_t              o_meta,
  output logic                    o_meta_valid,
  input  logic                    i_data_pop,
  output logic [`ORDE_DATA_W-1:0] o_data
);

  logic [31:0] base_a;
  logic [31:0] base_b;
  logic [31:0] base_c;
  orde_word_u  stored_word;
  orde_meta_t  head_meta;
  logic        head_valid;
  logic        meta_pop;

  orde_base_regs u_base_regs (
    .clk       (clk),
    .rst       (rst),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .o_prdata  (o_prdata),
    .o_pready  (o_pready),
    .o_pslverr (o_pslverr),
    .o_base_a  (base_a),
    .o_base_b  (base_b),
    .o_base_c  (base_c)
  );

  // incoming word rewritten in the accepting cycle
  orde_indirect_rewrite u_indirect_rewrite (
    .i_word   (i_pkt_data),
    .i_base_a (base_a),
    .i_base_b (base_b),
    .i_base_c (base_c),
    .o_word   (stored_word)
  );

  orde_resp_store u_resp_store (
    .clk          (clk),
    .rst          (rst),
    .i_pkt_valid  (i_pkt_valid),
    .i_pkt_meta   (i_pkt_meta),
    .i_pkt_word   (stored_word),
    .i_data_pop   (i_data_pop),
    .i_meta_pop   (meta_pop),
    .o_pkt_rdy    (o_pkt_rdy),
    .o_head_meta  (head_meta),
    .o_head_valid (head_valid),
    .o_data       (o_data)
  );

  orde_dup_filter u_dup_filter (
    .clk          (clk),
    .rst          (rst),
    .i_head_meta  (head_meta),
    .i_head_valid (head_valid),
    .o_meta_pop   (meta_pop),
    .o_meta       (o_meta),
    .o_meta_valid (o_meta_valid)
  );

endmodule

`default_nettype wire

// ==== source/orde_dup_filter.sv ====
`timescale 1ns/1ns
`default_nettype none

module orde_dup_filter
  import orde_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  orde_meta_t i_head_meta,
  input  logic       i_head_valid,
  output logic       o_meta_pop,
  output orde_meta_t o_meta,
  output logic       o_meta_valid
);

  // o_meta holds the newest presented entry, last2 the one before
  orde_meta_t last2;
  logic       last1_v;
  logic       last2_v;
  logic       pop_en;
  logic       match1;
  logic       match2;
  logic       head_take;

  assign match1 = last1_v && (i_head_meta == o_meta);
  assign match2 = last2_v && (i_head_meta == last2);

  // head is shown or dropped in every popping cycle
  assign head_take = o_meta_pop && i_head_valid && !(match1 || match2);

  // start pulling heads once out of reset
  assign o_meta_pop = pop_en;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pop_en       <= 1'b0;
      o_meta_valid <= 1'b0;
      last1_v      <= 1'b0;
      last2_v      <= 1'b0;
    end else begin
      pop_en       <= 1'b1;
      o_meta_valid <= head_take;
      if (head_take) begin
        last1_v <= 1'b1;
        last2_v <= last1_v;
      end
    end
  end

  // history shifts only when an entry is presented
  always_ff @(posedge clk) begin
    if (head_take) begin
      o_meta <= i_head_meta;
      last2  <= o_meta;
    end
  end

endmodule

`default_nettype wire

// ==== source/orde_resp_store.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "orde_defines.svh"

module orde_resp_store
  import orde_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_pkt_valid,
  input  orde_meta_t              i_pkt_meta,
  input  orde_word_u              i_pkt_word,
  input  logic                    i_data_pop,
  input  logic                    i_meta_pop,
  output logic                    o_pkt_rdy,
  output orde_meta_t              o_head_meta,
  output logic                    o_head_valid,
  output logic [`ORDE_DATA_W-1:0] o_data
);

  localparam int PTR_W = $clog2(`ORDE_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  orde_meta_t              meta_mem [`ORDE_DEPTH];
  logic [`ORDE_DATA_W-1:0] data_mem [`ORDE_DEPTH];

  logic [PTR_W-1:0] ins_ptr;
  logic [PTR_W-1:0] meta_ptr;
  logic [PTR_W-1:0] data_ptr;
  logic [PTR_W-1:0] data_ptr_next;
  logic [CNT_W-1:0] meta_cnt;
  logic [CNT_W-1:0] data_cnt;
  logic             pkt_insert;
  logic             meta_pop_ok;
  logic             data_pop_ok;

  // keep two slots of slack behind the producer
  assign o_pkt_rdy  = data_cnt < CNT_W'(`ORDE_DEPTH - 2);
  assign pkt_insert = i_pkt_valid && o_pkt_rdy;

  // pops only count while entries are stored
  assign meta_pop_ok = i_meta_pop && (meta_cnt != '0);
  assign data_pop_ok = i_data_pop && (data_cnt != '0);

  assign data_ptr_next = data_pop_ok ? data_ptr + PTR_W'(1) : data_ptr;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ins_ptr      <= '0;
      meta_ptr     <= '0;
      data_ptr     <= '0;
      meta_cnt     <= '0;
      data_cnt     <= '0;
      o_head_valid <= 1'b0;
    end else begin
      if (pkt_insert) begin
        ins_ptr <= ins_ptr + PTR_W'(1);
      end
      if (meta_pop_ok) begin
        meta_ptr <= meta_ptr + PTR_W'(1);
      end
      data_ptr <= data_ptr_next;

      case ({pkt_insert, meta_pop_ok})
        2'b10:   meta_cnt <= meta_cnt + CNT_W'(1);
        2'b01:   meta_cnt <= meta_cnt - CNT_W'(1);
        default: meta_cnt <= meta_cnt;
      endcase

      case ({pkt_insert, data_pop_ok})
        2'b10:   data_cnt <= data_cnt + CNT_W'(1);
        2'b01:   data_cnt <= data_cnt - CNT_W'(1);
        default: data_cnt <= data_cnt;
      endcase

      // head is empty when popped from an empty store
      if (i_meta_pop) begin
        o_head_valid <= (meta_cnt != '0);
      end
    end
  end

  // both memories share the insert slot
  always_ff @(posedge clk) begin
    if (pkt_insert) begin
      meta_mem[ins_ptr] <= i_pkt_meta;
      data_mem[ins_ptr] <= i_pkt_word.raw;
    end
    if (meta_pop_ok) begin
      o_head_meta <= meta_mem[meta_ptr];
    end
    // oldest unpopped word, one edge behind the pointer
    o_data <= data_mem[data_ptr_next];
  end

endmodule

`default_nettype wire

// ==== source/orde_indirect_rewrite.sv ====
`timescale 1ns/1ns
`default_nettype none

module orde_indirect_rewrite
  import orde_pkg::*;
(
  input  orde_word_u  i_word,
  input  logic [31:0] i_base_a,
  input  logic [31:0] i_base_b,
  input  logic [31:0] i_base_c,
  output orde_word_u  o_word
);

  logic        is_read_desc;
  logic        imm_indirect;
  logic        rewrite_en;
  logic        sel_ab;
  logic        sel_c;
  logic [31:0] base_sel;
  logic [31:0] field_sel;
  logic [31:0] field_sum;

  // read descriptor signature in the two address words
  assign is_read_desc = (i_word.desc.addr_h == 32'd4) &&
                        (i_word.desc.addr_l[31:24] == 8'h00) &&
                        i_word.desc.addr_l[23] &&
                        ((i_word.desc.addr_l[5:0] == 6'd3) ||
                         (i_word.desc.addr_l[5:0] == 6'd5));

  // bit 0 indirect, bit 1 immediate offset
  assign imm_indirect = i_word.desc.addr_l[0] && i_word.desc.addr_l[1];
  assign rewrite_en   = is_read_desc && imm_indirect;

  // opcode bit 1 wins over bit 2, bit 2 over bit 3
  always_comb begin
    sel_ab    = 1'b0;
    sel_c     = 1'b0;
    base_sel  = '0;
    field_sel = i_word.desc.off_ab;
    if (rewrite_en) begin
      if (i_word.desc.opcode[1]) begin
        sel_ab   = 1'b1;
        base_sel = i_base_a;
      end else if (i_word.desc.opcode[2]) begin
        sel_ab   = 1'b1;
        base_sel = i_base_b;
      end else if (i_word.desc.opcode[3]) begin
        sel_c     = 1'b1;
        base_sel  = i_base_c;
        field_sel = i_word.desc.off_c;
      end
    end
  end

  // wraps modulo 2^32
  assign field_sum = field_sel + base_sel;

  always_comb begin
    o_word = i_word;
    if (sel_ab) begin
      o_word.desc.off_ab = field_sum;
    end
    if (sel_c) begin
      o_word.desc.off_c = field_sum;
    end
  end

endmodule

`default_nettype wire

// ==== source/orde_base_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "orde_defines.svh"

module orde_base_regs (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_psel,
  input  logic                    i_penable,
  input  logic                    i_pwrite,
  input  logic [`ORDE_APB_AW-1:0] i_paddr,
  input  logic [31:0]             i_pwdata,
  output logic [31:0]             o_prdata,
  output logic                    o_pready,
  output logic                    o_pslverr,
  output logic [31:0]             o_base_a,
  output logic [31:0]             o_base_b,
  output logic [31:0]             o_base_c
);

  logic hit_a;
  logic hit_b;
  logic hit_c;
  logic mapped;
  logic access;
  logic wr_en;

  // address decode
  assign hit_a  = (i_paddr == `ORDE_REG_A_OFS);
  assign hit_b  = (i_paddr == `ORDE_REG_B_OFS);
  assign hit_c  = (i_paddr == `ORDE_REG_C_OFS);
  assign mapped = hit_a || hit_b || hit_c;

  // access phase of a transfer
  assign access = i_psel && i_penable;
  assign wr_en  = access && i_pwrite && mapped;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_base_a <= '0;
      o_base_b <= '0;
      o_base_c <= '0;
    end else if (wr_en) begin
      if (hit_a) begin
        o_base_a <= i_pwdata;
      end
      if (hit_b) begin
        o_base_b <= i_pwdata;
      end
      if (hit_c) begin
        o_base_c <= i_pwdata;
      end
    end
  end

  // read data, zero for unmapped offsets
  always_comb begin
    o_prdata = '0;
    if (access && !i_pwrite) begin
      if (hit_a) begin
        o_prdata = o_base_a;
      end else if (hit_b) begin
        o_prdata = o_base_b;
      end else if (hit_c) begin
        o_prdata = o_base_c;
      end
    end
  end

  // no wait states
  assign o_pready  = 1'b1;
  assign o_pslverr = access && !mapped;

endmodule

`default_nettype wire

// ==== source/orde_pkg.sv ====
`default_nettype none

`include "orde_defines.svh"

package orde_pkg;

  // kind of read that produced the response
  typedef enum logic {
    RD_NORMAL = 1'b0,
    RD_DESC   = 1'b1
  } rd_kind_e;

  // metadata kept per response, 31 bits
  typedef struct packed {
    rd_kind_e                kind;
    logic [`ORDE_CH_W-1:0]   ch;
    logic [`ORDE_BK_W-1:0]   bk;
    logic [`ORDE_ROW_W-1:0]  row;
    logic [`ORDE_COL_W-1:0]  col;
  } orde_meta_t;

  // dma descriptor layout, word 0 in the low bits
  typedef struct packed {
    logic [31:0] opcode;
    logic [31:0] w6;
    logic [31:0] w5;
    logic [31:0] off_c;
    logic [31:0] w3;
    logic [31:0] off_ab;
    logic [31:0] addr_h;
    logic [31:0] addr_l;
  } orde_desc_t;

  // one data word, seen raw or as a descriptor
  typedef union packed {
    logic [`ORDE_DATA_W-1:0] raw;
    orde_desc_t              desc;
  } orde_word_u;

endpackage

`default_nettype wire

// ==== source/orde_defines.svh ====
`ifndef ORDE_DEFINES_SVH
`define ORDE_DEFINES_SVH

// buffer geometry
`define ORDE_DEPTH 8
`define ORDE_DATA_W 256

// response metadata field widths
`define ORDE_CH_W 2
`define ORDE_BK_W 4
`define ORDE_ROW_W 14
`define ORDE_COL_W 10

// apb map of the indirect base registers
`define ORDE_APB_AW 4
`define ORDE_REG_A_OFS 4'h0
`define ORDE_REG_B_OFS 4'h4
`define ORDE_REG_C_OFS 4'h8

`endif
